// File: hdl/icache_pkg.sv
// ======================================================================
// geometry and shared types for the instruction cache
// associativity is fixed at 4 since the 3-bit LRU tree depends on it
// index and tag widths depend on the set count and are derived per module
// ======================================================================
`default_nettype none

package icache_pkg;

  localparam int ways_c = 4;
  localparam int sets_c = 64;

  localparam int paddr_width_c = 32;
  localparam int dword_width_c = 64;
  localparam int instr_width_c = 32;

  // byte within a doubleword
  localparam int byte_offset_width_c = 3;
  // doubleword within a line
  localparam int word_offset_width_c = 2;
  // 32-byte line
  localparam int block_offset_width_c = byte_offset_width_c + word_offset_width_c;

  typedef logic [1:0] way_t;

  typedef logic [paddr_width_c-1:0] addr_t;

  typedef logic [dword_width_c-1:0] dword_t;

  typedef logic [instr_width_c-1:0] instr_t;

  // doubleword 0 of the line in the low bits
  typedef dword_t [ways_c-1:0] block_t;

  // bit 0 root, bit 1 ways 0/1, bit 2 ways 2/3
  typedef logic [2:0] lru_t;

endpackage

`default_nettype wire

// File: hdl/icache_if.sv
// ======================================================================
// fill_if carries one whole-line write to the tag and data arrays
// lookup_if carries the TV-stage lookup results, registered at the source
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

interface fill_if #(
  parameter int sets_p = icache_pkg::sets_c
) ();

  localparam int index_width_lp = $clog2(sets_p);
  localparam int tag_width_lp =
    icache_pkg::paddr_width_c - icache_pkg::block_offset_width_c - index_width_lp;

  logic                      fill_v;
  logic [index_width_lp-1:0] fill_index;
  icache_pkg::way_t          fill_way;
  logic [tag_width_lp-1:0]   fill_tag;
  icache_pkg::block_t        fill_block;

  modport ctrl (
    output fill_v, fill_index, fill_way, fill_tag, fill_block
  );

  modport array (
    input fill_v, fill_index, fill_way, fill_tag, fill_block
  );

endinterface

interface lookup_if ();

  logic             hit;
  icache_pkg::way_t hit_way;
  logic             invalid_exist;
  icache_pkg::way_t invalid_way;

  modport src (
    output hit, hit_way, invalid_exist, invalid_way
  );

  modport dst (
    input hit, hit_way, invalid_exist, invalid_way
  );

endinterface

`default_nettype wire

// File: hdl/sync_ram.sv
// ======================================================================
// one read port, one write port, registered read data
// read and write to the same address in one cycle return the old data
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module sync_ram #(
  parameter int  depth_p   = 64,
  parameter type payload_t = logic [7:0]
) (
  input  wire logic                       clk_i,
  input  wire logic                       re_i,
  input  wire logic [$clog2(depth_p)-1:0] raddr_i,
  output payload_t                        rdata_o,
  input  wire logic                       we_i,
  input  wire logic [$clog2(depth_p)-1:0] waddr_i,
  input  wire payload_t                   wdata_i
);

  payload_t mem_r [depth_p];

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem_r[waddr_i] <= wdata_i;
    end
    // output holds while re_i is low
    if (re_i) begin
      rdata_o <= mem_r[raddr_i];
    end
  end

endmodule

`default_nettype wire

// File: hdl/icache_tag_lookup.sv
// ======================================================================
// per-way tag RAMs plus valid flops, compared in TL and registered to TV
// a fill never coincides with a fetch read, so no bypass is provided
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module icache_tag_lookup #(
  parameter int sets_p = icache_pkg::sets_c
) (
  input  wire logic              clk_i,
  input  wire logic              reset_i,
  input  wire logic              fetch_accept_i,
  input  wire icache_pkg::addr_t fetch_addr_i,
  fill_if.array                  fill,
  lookup_if.src                  result
);

  localparam int index_width_lp = $clog2(sets_p);
  localparam int tag_width_lp =
    icache_pkg::paddr_width_c - icache_pkg::block_offset_width_c - index_width_lp;

  typedef logic [tag_width_lp-1:0] tag_t;

  logic [index_width_lp-1:0] fetch_index;
  tag_t                      fetch_tag;
  tag_t                      tag_tl_r;
  tag_t [icache_pkg::ways_c-1:0] way_tag;

  logic [sets_p-1:0][icache_pkg::ways_c-1:0] valid_r;
  logic [icache_pkg::ways_c-1:0] valid_tl_r;
  logic [icache_pkg::ways_c-1:0] hit_v;

  function automatic icache_pkg::way_t lowest_way(input logic [icache_pkg::ways_c-1:0] v);
    icache_pkg::way_t way;
    way = '0;
    for (int w = icache_pkg::ways_c - 1; w >= 0; w--) begin
      if (v[w]) begin
        way = icache_pkg::way_t'(w);
      end
    end
    return way;
  endfunction

  assign fetch_index = fetch_addr_i[icache_pkg::block_offset_width_c +: index_width_lp];
  assign fetch_tag =
    fetch_addr_i[icache_pkg::block_offset_width_c + index_width_lp +: tag_width_lp];

  for (genvar w = 0; w < icache_pkg::ways_c; w++) begin : g_way
    sync_ram #(
      .depth_p  (sets_p),
      .payload_t(tag_t)
    ) i_tag_ram (
      .clk_i  (clk_i),
      .re_i   (fetch_accept_i),
      .raddr_i(fetch_index),
      .rdata_o(way_tag[w]),
      .we_i   (fill.fill_v && (fill.fill_way == icache_pkg::way_t'(w))),
      .waddr_i(fill.fill_index),
      .wdata_i(fill.fill_tag)
    );

    assign hit_v[w] = valid_tl_r[w] && (way_tag[w] == tag_tl_r);
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_r <= '0;
    end else if (fill.fill_v) begin
      valid_r[fill.fill_index][fill.fill_way] <= 1'b1;
    end
  end

  // read side of TL, lined up with the RAM outputs
  always_ff @(posedge clk_i) begin
    if (fetch_accept_i) begin
      tag_tl_r   <= fetch_tag;
      valid_tl_r <= valid_r[fetch_index];
    end
  end

  always_ff @(posedge clk_i) begin
    result.hit           <= |hit_v;
    result.hit_way       <= lowest_way(hit_v);
    result.invalid_exist <= ~&valid_tl_r;
    result.invalid_way   <= lowest_way(~valid_tl_r);
  end

endmodule

`default_nettype wire

// File: hdl/icache_data_banks.sv
// ======================================================================
// four doubleword banks, one per way, with positions swizzled by way
// bank b at offset o holds doubleword o of way b xor o
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module icache_data_banks #(
  parameter int sets_p = icache_pkg::sets_c
) (
  input  wire logic                                 clk_i,
  input  wire logic                                 fetch_accept_i,
  input  wire icache_pkg::addr_t                    fetch_addr_i,
  fill_if.array                                     fill,
  output icache_pkg::dword_t [icache_pkg::ways_c-1:0] block_o
);

  localparam int index_width_lp = $clog2(sets_p);
  localparam int bank_depth_lp = sets_p * icache_pkg::ways_c;
  localparam int bank_addr_width_lp = index_width_lp + icache_pkg::word_offset_width_c;

  logic [index_width_lp-1:0] fetch_index;
  icache_pkg::way_t          fetch_word;
  logic [bank_addr_width_lp-1:0] read_addr;

  icache_pkg::dword_t [icache_pkg::ways_c-1:0] bank_rdata;

  assign fetch_index = fetch_addr_i[icache_pkg::block_offset_width_c +: index_width_lp];
  assign fetch_word =
    fetch_addr_i[icache_pkg::byte_offset_width_c +: icache_pkg::word_offset_width_c];

  // every bank reads the same position
  assign read_addr = {fetch_index, fetch_word};

  for (genvar b = 0; b < icache_pkg::ways_c; b++) begin : g_bank
    icache_pkg::way_t               fill_word;
    logic [bank_addr_width_lp-1:0]  write_addr;

    assign fill_word  = fill.fill_way ^ icache_pkg::way_t'(b);
    assign write_addr = {fill.fill_index, fill_word};

    sync_ram #(
      .depth_p  (bank_depth_lp),
      .payload_t(icache_pkg::dword_t)
    ) i_bank_ram (
      .clk_i  (clk_i),
      .re_i   (fetch_accept_i),
      .raddr_i(read_addr),
      .rdata_o(bank_rdata[b]),
      .we_i   (fill.fill_v),
      .waddr_i(write_addr),
      .wdata_i(fill.fill_block[fill_word])
    );
  end

  // into TV, alongside the tag results
  always_ff @(posedge clk_i) begin
    block_o <= bank_rdata;
  end

endmodule

`default_nettype wire

// File: hdl/icache_resolve.sv
// ======================================================================
// stage valids, LRU flops, the single outstanding miss and output select
// the missed access is not replayed; the fetch unit refetches after fill
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module icache_resolve #(
  parameter int sets_p = icache_pkg::sets_c
) (
  input  wire logic                                 clk_i,
  input  wire logic                                 reset_i,
  input  wire logic                                 fetch_v_i,
  input  wire icache_pkg::addr_t                    fetch_addr_i,
  output logic                                      fetch_ready_o,
  output logic                                      fetch_accept_o,
  lookup_if.dst                                     lookup,
  input  wire icache_pkg::dword_t [icache_pkg::ways_c-1:0] block_i,
  fill_if.ctrl                                      fill,
  output logic                                      miss_req_v_o,
  output icache_pkg::addr_t                         miss_req_addr_o,
  input  wire logic                                 miss_req_ready_i,
  input  wire logic                                 fill_v_i,
  input  wire icache_pkg::block_t                   fill_data_i,
  output logic                                      data_v_o,
  output icache_pkg::instr_t                        data_o,
  output logic                                      miss_o
);

  localparam int index_width_lp = $clog2(sets_p);
  localparam int tag_width_lp =
    icache_pkg::paddr_width_c - icache_pkg::block_offset_width_c - index_width_lp;

  typedef enum logic [1:0] {idle_s, req_s, wait_fill_s, fill_s} state_e;

  state_e state_r;

  logic              v_tl_r;
  logic              v_tv_r;
  icache_pkg::addr_t addr_tl_r;
  icache_pkg::addr_t addr_tv_r;
  logic              miss_tv;

  logic [index_width_lp-1:0] index_tv;
  icache_pkg::way_t          word_tv;
  icache_pkg::dword_t        sel_dword;

  icache_pkg::lru_t lru_r [sets_p];
  icache_pkg::addr_t miss_addr_r;
  icache_pkg::way_t  victim_r;
  icache_pkg::block_t fill_block_r;

  function automatic icache_pkg::way_t lru_victim(input icache_pkg::lru_t tree);
    logic child;
    child = tree[0] ? tree[2] : tree[1];
    return {tree[0], child};
  endfunction

  // point the tree away from the way just used
  function automatic icache_pkg::lru_t lru_touch(input icache_pkg::lru_t tree,
                                                 input icache_pkg::way_t way);
    icache_pkg::lru_t upd;
    upd = tree;
    upd[0] = ~way[1];
    if (way[1]) begin
      upd[2] = ~way[0];
    end else begin
      upd[1] = ~way[0];
    end
    return upd;
  endfunction

  assign miss_tv        = v_tv_r && !lookup.hit;
  assign fetch_ready_o  = (state_r == idle_s) && !miss_tv;
  assign fetch_accept_o = fetch_v_i && fetch_ready_o;

  assign index_tv = addr_tv_r[icache_pkg::block_offset_width_c +: index_width_lp];
  assign word_tv  =
    addr_tv_r[icache_pkg::byte_offset_width_c +: icache_pkg::word_offset_width_c];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_tl_r <= 1'b0;
      v_tv_r <= 1'b0;
    end else begin
      v_tl_r <= fetch_accept_o;
      // a miss squashes whatever sits in TL
      v_tv_r <= v_tl_r && !miss_tv;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fetch_accept_o) begin
      addr_tl_r <= fetch_addr_i;
    end
    if (v_tl_r) begin
      addr_tv_r <= addr_tl_r;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int s = 0; s < sets_p; s++) begin
        lru_r[s] <= '0;
      end
    end else if (data_v_o) begin
      lru_r[index_tv] <= lru_touch(lru_r[index_tv], lookup.hit_way);
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= idle_s;
    end else begin
      case (state_r)
        idle_s:      if (miss_tv) state_r <= req_s;
        req_s:       if (miss_req_ready_i) state_r <= wait_fill_s;
        wait_fill_s: if (fill_v_i) state_r <= fill_s;
        default:     state_r <= idle_s;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_r == idle_s) && miss_tv) begin
      miss_addr_r <= {addr_tv_r[icache_pkg::paddr_width_c-1:icache_pkg::block_offset_width_c],
                      {icache_pkg::block_offset_width_c{1'b0}}};
      // invalid way first, else the tree victim
      victim_r    <= lookup.invalid_exist ? lookup.invalid_way : lru_victim(lru_r[index_tv]);
    end
    if ((state_r == wait_fill_s) && fill_v_i) begin
      fill_block_r <= fill_data_i;
    end
  end

  assign miss_req_v_o    = (state_r == req_s);
  assign miss_req_addr_o = miss_addr_r;

  assign fill.fill_v     = (state_r == fill_s);
  assign fill.fill_index = miss_addr_r[icache_pkg::block_offset_width_c +: index_width_lp];
  assign fill.fill_tag   =
    miss_addr_r[icache_pkg::block_offset_width_c + index_width_lp +: tag_width_lp];
  assign fill.fill_way   = victim_r;
  assign fill.fill_block = fill_block_r;

  assign data_v_o = v_tv_r && lookup.hit;
  assign miss_o   = miss_tv;

  // banks are swizzled, so undo it with the word offset
  assign sel_dword = block_i[lookup.hit_way ^ word_tv];
  assign data_o = addr_tv_r[icache_pkg::byte_offset_width_c-1]
                ? sel_dword[icache_pkg::instr_width_c +: icache_pkg::instr_width_c]
                : sel_dword[icache_pkg::instr_width_c-1:0];

endmodule

`default_nettype wire

// File: hdl/icache_top.sv
// ======================================================================
// 4-way instruction cache, physical fetch address, two-stage lookup
// results appear two cycles after acceptance; one line miss at a time
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module icache_top #(
  parameter int sets_p = icache_pkg::sets_c
) (
  input  wire logic               clk_i,
  input  wire logic               reset_i,

  input  wire logic               fetch_v_i,
  input  wire icache_pkg::addr_t  fetch_addr_i,
  output logic                    fetch_ready_o,

  output logic                    data_v_o,
  output icache_pkg::instr_t      data_o,
  output logic                    miss_o,

  output logic                    miss_req_v_o,
  output icache_pkg::addr_t       miss_req_addr_o,
  input  wire logic               miss_req_ready_i,

  input  wire logic               fill_v_i,
  input  wire icache_pkg::block_t fill_data_i
);

  logic fetch_accept;
  icache_pkg::dword_t [icache_pkg::ways_c-1:0] bank_block;

  fill_if #(.sets_p(sets_p)) fill_bus ();
  lookup_if lookup_bus ();

  icache_tag_lookup #(
    .sets_p(sets_p)
  ) i_icache_tag_lookup (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .fetch_accept_i(fetch_accept),
    .fetch_addr_i  (fetch_addr_i),
    .fill          (fill_bus.array),
    .result        (lookup_bus.src)
  );

  icache_data_banks #(
    .sets_p(sets_p)
  ) i_icache_data_banks (
    .clk_i         (clk_i),
    .fetch_accept_i(fetch_accept),
    .fetch_addr_i  (fetch_addr_i),
    .fill          (fill_bus.array),
    .block_o       (bank_block)
  );

  icache_resolve #(
    .sets_p(sets_p)
  ) i_icache_resolve (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .fetch_v_i       (fetch_v_i),
    .fetch_addr_i    (fetch_addr_i),
    .fetch_ready_o   (fetch_ready_o),
    .fetch_accept_o  (fetch_accept),
    .lookup          (lookup_bus.dst),
    .block_i         (bank_block),
    .fill            (fill_bus.ctrl),
    .miss_req_v_o    (miss_req_v_o),
    .miss_req_addr_o (miss_req_addr_o),
    .miss_req_ready_i(miss_req_ready_i),
    .fill_v_i        (fill_v_i),
    .fill_data_i     (fill_data_i),
    .data_v_o        (data_v_o),
    .data_o          (data_o),
    .miss_o          (miss_o)
  );

endmodule

`default_nettype wire

// File: tb/tb_icache_tasks.svh
// ======================================================================
// memory rule, LFSR, cache model and directed tests for the icache bench
// every task starts and ends 1 ns after a rising edge
// ======================================================================

// instruction at word address a is a xor 5a5a0000
function automatic icache_pkg::instr_t mem_word(input icache_pkg::addr_t addr);
  return (addr >> 2) ^ 32'h5A5A0000;
endfunction

function automatic icache_pkg::block_t mem_line(input icache_pkg::addr_t line);
  icache_pkg::block_t blk;
  icache_pkg::addr_t  lo;
  for (int d = 0; d < icache_pkg::ways_c; d++) begin
    lo = line + icache_pkg::addr_t'(8 * d);
    blk[d] = {mem_word(lo + 32'd4), mem_word(lo)};
  end
  return blk;
endfunction

function automatic icache_pkg::addr_t make_addr(input int tag, input int set, input int word);
  return (icache_pkg::addr_t'(tag) << tag_shift_c)
       | (icache_pkg::addr_t'(set) << icache_pkg::block_offset_width_c)
       | (icache_pkg::addr_t'(word) << 2);
endfunction

function automatic int set_of(input icache_pkg::addr_t addr);
  return int'(addr[icache_pkg::block_offset_width_c +: index_width_c]);
endfunction

function automatic icache_pkg::addr_t line_of(input icache_pkg::addr_t addr);
  return addr & ~icache_pkg::addr_t'((1 << icache_pkg::block_offset_width_c) - 1);
endfunction

// x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_step(input logic [15:0] s);
  logic fb;
  fb = s[15] ^ s[13] ^ s[12] ^ s[10];
  return {s[14:0], fb};
endfunction

function automatic int take_bits(input int n);
  int v;
  v = 0;
  for (int i = 0; i < n; i++) begin
    lfsr_r = lfsr_step(lfsr_r);
    v = (v << 1) | int'(lfsr_r[0]);
  end
  return v;
endfunction

// root and child point away from the way just hit
function automatic icache_pkg::lru_t lru_after_hit(input icache_pkg::lru_t tree, input int way);
  icache_pkg::lru_t t;
  t = tree;
  t[0] = (way < 2);
  if (way < 2) begin
    t[1] = (way == 0);
  end else begin
    t[2] = (way == 2);
  end
  return t;
endfunction

function automatic int model_victim(input int set);
  icache_pkg::lru_t t;
  int way;
  bit found;
  found = 1'b0;
  way = 0;
  for (int w = 0; w < icache_pkg::ways_c; w++) begin
    if (!found && !model_valid[set][w]) begin
      way = w;
      found = 1'b1;
    end
  end
  if (!found) begin
    t = model_lru[set];
    if (t[0]) begin
      way = 2 + int'(t[2]);
    end else begin
      way = int'(t[1]);
    end
  end
  return way;
endfunction

function automatic int model_way(input icache_pkg::addr_t addr);
  int way;
  way = -1;
  for (int w = 0; w < icache_pkg::ways_c; w++) begin
    if (model_valid[set_of(addr)][w] && model_line[set_of(addr)][w] == line_of(addr)) begin
      way = w;
    end
  end
  return way;
endfunction

function automatic void clear_model();
  for (int s = 0; s < icache_pkg::sets_c; s++) begin
    model_lru[s] = '0;
    for (int w = 0; w < icache_pkg::ways_c; w++) begin
      model_valid[s][w] = 1'b0;
      model_line[s][w] = '0;
    end
  end
endfunction

task automatic check_quiet(input string when);
  check_flag({"data_v_o ", when}, data_v_o, 1'b0);
  check_flag({"miss_o ", when}, miss_o, 1'b0);
  check_flag({"miss_req_v_o ", when}, miss_req_v_o, 1'b0);
  check_flag({"fetch_ready_o ", when}, fetch_ready_o, 1'b1);
endtask

task automatic wait_ready();
  int n;
  n = 0;
  while (!fetch_ready_o && n < 40) begin
    next_cycle();
    n++;
  end
  assert (fetch_ready_o) else begin
    errors++;
    $display("fetch_ready_o did not return within 40 cycles of a miss at %0t ns", $time);
  end
endtask

// one fetch per cycle, every one expected to hit
task automatic stream_hits(input icache_pkg::addr_t addrs[$]);
  icache_pkg::addr_t a;
  int n;
  int way;
  n = addrs.size();
  for (int i = 0; i < n + 2; i++) begin
    if (i < n) begin
      fetch_v_i = 1'b1;
      fetch_addr_i = addrs[i];
      check_flag("fetch_ready_o in stream", fetch_ready_o, 1'b1);
    end else begin
      fetch_v_i = 1'b0;
    end
    if (i < 2) begin
      check_flag("data_v_o before first result", data_v_o, 1'b0);
    end else begin
      a = addrs[i-2];
      check_flag("data_v_o", data_v_o, 1'b1);
      check_flag("miss_o on hit", miss_o, 1'b0);
      check_word("data_o", data_o, mem_word(a));
      way = model_way(a);
      model_lru[set_of(a)] = lru_after_hit(model_lru[set_of(a)], way);
    end
    next_cycle();
  end
endtask

task automatic miss_and_fill(input icache_pkg::addr_t addr);
  int way;
  way = model_victim(set_of(addr));
  fetch_v_i = 1'b1;
  fetch_addr_i = addr;
  check_flag("fetch_ready_o before miss", fetch_ready_o, 1'b1);
  next_cycle();
  fetch_v_i = 1'b0;
  check_flag("miss_o one cycle early", miss_o, 1'b0);
  next_cycle();
  check_flag("miss_o", miss_o, 1'b1);
  check_flag("data_v_o on miss", data_v_o, 1'b0);
  check_flag("fetch_ready_o on miss", fetch_ready_o, 1'b0);
  next_cycle();
  check_flag("miss_req_v_o", miss_req_v_o, 1'b1);
  check_word("miss_req_addr_o", miss_req_addr_o, line_of(addr));
  wait_ready();
  model_valid[set_of(addr)][way] = 1'b1;
  model_line[set_of(addr)][way] = line_of(addr);
endtask

task automatic cold_miss_then_hit();
  icache_pkg::addr_t q[$];
  q.push_back(make_addr(1, 1, 3));
  miss_and_fill(q[0]);
  stream_hits(q);
endtask

// (i * 5) % 8 visits all eight words of the line
task automatic back_to_back_hits();
  icache_pkg::addr_t q[$];
  for (int i = 0; i < 8; i++) begin
    q.push_back(make_addr(1, 1, (i * 5) % 8));
  end
  stream_hits(q);
endtask

task automatic fill_all_ways();
  icache_pkg::addr_t q[$];
  for (int t = 1; t <= 4; t++) begin
    miss_and_fill(make_addr(t, 3, t));
  end
  for (int w = 0; w < 8; w++) begin
    for (int t = 1; t <= 4; t++) begin
      q.push_back(make_addr(t, 3, w));
    end
  end
  stream_hits(q);
endtask

task automatic lru_eviction();
  icache_pkg::addr_t q[$];
  icache_pkg::addr_t evicted;
  for (int t = 1; t <= 4; t++) begin
    miss_and_fill(make_addr(t, 4, 0));
  end
  // touch ways 0, 2, 1, 3, 0
  q.push_back(make_addr(1, 4, 1));
  q.push_back(make_addr(3, 4, 2));
  q.push_back(make_addr(2, 4, 3));
  q.push_back(make_addr(4, 4, 4));
  q.push_back(make_addr(1, 4, 5));
  stream_hits(q);
  evicted = model_line[4][model_victim(4)];
  miss_and_fill(make_addr(5, 4, 3));
  q.delete();
  for (int w = 0; w < icache_pkg::ways_c; w++) begin
    q.push_back(model_line[4][w] + icache_pkg::addr_t'(4 * w + 4));
  end
  stream_hits(q);
  miss_and_fill(evicted + 32'd8);
endtask

task automatic squash_behind_miss();
  icache_pkg::addr_t q[$];
  icache_pkg::addr_t a_addr;
  icache_pkg::addr_t b_addr;
  int way;
  a_addr = make_addr(1, 5, 2);
  b_addr = make_addr(1, 1, 6);
  way = model_victim(5);
  hold_req = 1'b1;
  fetch_v_i = 1'b1;
  fetch_addr_i = a_addr;
  next_cycle();
  fetch_addr_i = b_addr;
  check_flag("fetch_ready_o behind miss", fetch_ready_o, 1'b1);
  next_cycle();
  fetch_v_i = 1'b0;
  check_flag("miss_o", miss_o, 1'b1);
  check_flag("fetch_ready_o on miss", fetch_ready_o, 1'b0);
  next_cycle();
  // the fetch behind the miss was squashed
  check_flag("data_v_o after squash", data_v_o, 1'b0);
  check_flag("miss_o after squash", miss_o, 1'b0);
  for (int i = 0; i < 6; i++) begin
    check_flag("miss_req_v_o held", miss_req_v_o, 1'b1);
    check_word("miss_req_addr_o held", miss_req_addr_o, line_of(a_addr));
    next_cycle();
  end
  hold_req = 1'b0;
  wait_ready();
  model_valid[5][way] = 1'b1;
  model_line[5][way] = line_of(a_addr);
  q.push_back(b_addr);
  q.push_back(a_addr);
  stream_hits(q);
endtask

task automatic reset_mid_run();
  icache_pkg::addr_t q[$];
  q.push_back(make_addr(1, 1, 5));
  stream_hits(q);
  // a hit in flight when reset arrives
  fetch_v_i = 1'b1;
  fetch_addr_i = q[0];
  next_cycle();
  fetch_v_i = 1'b0;
  reset_i = 1'b1;
  repeat (3) begin
    next_cycle();
    check_quiet("during reset");
  end
  reset_i = 1'b0;
  check_quiet("after mid-run reset");
  clear_model();
  miss_and_fill(q[0]);
endtask

// File: tb/tb_icache.sv
// ======================================================================
// directed testbench for the instruction cache, inputs driven 1 ns after
// the rising edge; the memory responder serves one line miss at a time
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module tb_icache;

  localparam int num_tests_c = 6;
  localparam int index_width_c = $clog2(icache_pkg::sets_c);
  localparam int tag_shift_c = icache_pkg::block_offset_width_c + index_width_c;

  logic               clk_i;
  logic               reset_i;
  logic               fetch_v_i;
  icache_pkg::addr_t  fetch_addr_i;
  logic               fetch_ready_o;
  logic               data_v_o;
  icache_pkg::instr_t data_o;
  logic               miss_o;
  logic               miss_req_v_o;
  icache_pkg::addr_t  miss_req_addr_o;
  logic               miss_req_ready_i;
  logic               fill_v_i;
  icache_pkg::block_t fill_data_i;

  int          checks;
  int          errors;
  logic        hold_req;
  logic [15:0] lfsr_r;

  // expected cache contents, kept by line address
  bit                model_valid [icache_pkg::sets_c][icache_pkg::ways_c];
  icache_pkg::addr_t model_line [icache_pkg::sets_c][icache_pkg::ways_c];
  icache_pkg::lru_t  model_lru [icache_pkg::sets_c];

  icache_top #(
    .sets_p(icache_pkg::sets_c)
  ) i_icache_top (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .fetch_v_i       (fetch_v_i),
    .fetch_addr_i    (fetch_addr_i),
    .fetch_ready_o   (fetch_ready_o),
    .data_v_o        (data_v_o),
    .data_o          (data_o),
    .miss_o          (miss_o),
    .miss_req_v_o    (miss_req_v_o),
    .miss_req_addr_o (miss_req_addr_o),
    .miss_req_ready_i(miss_req_ready_i),
    .fill_v_i        (fill_v_i),
    .fill_data_i     (fill_data_i)
  );

  always #50 clk_i = ~clk_i;

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("ERROR %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_word(input string what, input logic [31:0] got,
                            input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("ERROR %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  `include "tb_icache_tasks.svh"

  // memory responder
  initial begin
    icache_pkg::addr_t line;
    int gap;
    miss_req_ready_i = 1'b0;
    fill_v_i = 1'b0;
    fill_data_i = '0;
    forever begin
      next_cycle();
      if (miss_req_v_o && !hold_req) begin
        line = miss_req_addr_o;
        gap = take_bits(2);
        repeat (gap) next_cycle();
        check_flag("miss_req_v_o before accept", miss_req_v_o, 1'b1);
        check_word("miss_req_addr_o before accept", miss_req_addr_o, line);
        miss_req_ready_i = 1'b1;
        next_cycle();
        miss_req_ready_i = 1'b0;
        gap = 1 + take_bits(2) % 3;
        repeat (gap - 1) next_cycle();
        fill_v_i = 1'b1;
        fill_data_i = mem_line(line);
        next_cycle();
        fill_v_i = 1'b0;
      end
    end
  end

  initial begin
    clk_i = 1'b0;
    reset_i = 1'b1;
    fetch_v_i = 1'b0;
    fetch_addr_i = '0;
    hold_req = 1'b0;
    lfsr_r = 16'd20527;
    checks = 0;
    errors = 0;
    clear_model();
    repeat (3) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    check_quiet("after reset");
    cold_miss_then_hit();
    back_to_back_hits();
    fill_all_ways();
    lru_eviction();
    squash_behind_miss();
    reset_mid_run();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // watchdog
  initial begin
    repeat (num_tests_c * 200) @(posedge clk_i);
    $display("timeout: the tests did not finish within %0d cycles", num_tests_c * 200);
    $display("checks: %0d, errors: %0d", checks, errors);
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+tb
hdl/icache_pkg.sv
hdl/icache_if.sv
hdl/sync_ram.sv
hdl/icache_tag_lookup.sv
hdl/icache_data_banks.sv
hdl/icache_resolve.sv
hdl/icache_top.sv
tb/tb_icache.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_icache
FILELIST  := build.f

OBJ_DIR := obj_dir
SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard tb/*.svh)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf $(OBJ_DIR)
